//--- bench/reflect_tests.dat
# ray_id normal(x y z) dir(x y z) p_int(x y z) expected_dir(x y z), all hex
# each vector is three 16-bit components, x in the top four digits
01 000000004000 100020003000 000100020003 10002000d000
02 400000000000 100020003000 0a0b0c0d0e0f f00020003000
03 000040000000 100020003000 111122223333 1000e0003000
04 00000000c000 012304560789 fff0fff1fff2 01230456f877
05 000000004000 000000008000 123456789abc 000000008000
06 400000000000 800011112222 400040004000 800011112222
07 000000007fff 000000002000 000000000000 000000002006
08 200000000000 ffff12340000 0100020003ff 000112340000
09 200020000000 400000000000 7fff7fff7fff 2000e0000000
0a 2d412d410000 0000c0000000 800080008000 400000000000
0b 000000000000 abcd12345678 020406080a0c abcd12345678
0c 000040000000 000080000000 135724680000 000080000000
0d 000000004000 7fff80017fff cafe00001234 7fff80018001
0e 400000000000 000100020003 fedcba987654 ffff00020003
0f c00000000000 3fff0000c001 0000ffff0000 c0010000c001
10 000000004000 123456789abc 5a5a5a5a5a5a 123456786544
11 000040000000 fedcba987654 a5a5a5a5a5a5 fedc45687654
12 400000000000 0f0ff0f00f0f 3c3c3c3c3c3c f0f1f0f00f0f
13 0000c0000000 000010000000 00ff00ff00ff 0000f0000000
14 000000004000 000000000001 7f007f007f00 00000000ffff
15 200020000000 000040000000 111111111111 e00020000000
16 000020002000 000000004000 222222222222 0000e0002000
17 400000000000 400040004000 333333333333 c00040004000
18 000000007fff 00000000e000 444444444444 00000000dffe
19 000000004000 aaaa55555555 555555555555 aaaa5555aaab
1a 000040000000 000000010000 666666666666 0000ffff0000
1b 200000000000 000100000000 777777777777 000100000000
1c 200000000000 7fff00000000 888888888888 400100000000
1d 400000000000 000000000000 999999999999 000000000000
a5 000000004000 010203040506 aaaaaaaaaaaa 01020304fafa
5a 000040000000 135724680000 bbbbbbbbbbbb 1357db980000
ff 400000000000 600000000000 cccccccccccc a00000000000

//--- verilog.f
common/vec_math_pkg.sv
common/ray_if_pkg.sv
design/ray_fifo.sv
reflect_lane/reflector.sv
reflect_lane/reflect_lane.sv
design/ray_dispatch.sv
design/ray_collect.sv
design/reflect_unit.sv
bench/tb_reflect_unit.sv

//--- run.sh
#!/bin/sh
# Compile and run the reflect_unit testbench with Verilator.

cd "$(dirname "$0")" || { echo "cannot enter the project root"; exit 1; }

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_reflect_unit -o tb_reflect_unit
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_reflect_unit > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0

//--- bench/tb_reflect_unit.sv
`timescale 1ns/1ps

module tb_reflect_unit;

	localparam int NUM_LANES = 2;
	localparam int FIFO_DEPTH = 8;
	localparam int WAIT_LIMIT = 400;
	localparam int HOLD_FIRST = 8;
	localparam int HOLD_CYCLES = 12;
	localparam logic [31:0] SEED = 32'd30179;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	ray_if_pkg::hit_rec_t in_hit;
	logic                 in_stall;
	logic                 out_valid;
	ray_if_pkg::ray_out_t out_ray;
	logic                 out_stall;

	ray_if_pkg::hit_rec_t hits [$];
	ray_if_pkg::ray_out_t rays [$];
	ray_if_pkg::ray_out_t exp_q [$];
	ray_if_pkg::ray_out_t held_ray;
	ray_if_pkg::ray_out_t expected;
	logic                 held_valid;
	logic                 hold_stall;
	logic                 stall_next;
	logic                 saw_in_stall;
	logic [31:0]          gap_rng;
	logic [31:0]          stall_rng;

	reflect_unit #(
		.NUM_LANES  (NUM_LANES),
		.FIFO_DEPTH (FIFO_DEPTH)
	) reflect_unit_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_hit    (in_hit),
		.in_stall  (in_stall),
		.out_valid (out_valid),
		.out_ray   (out_ray),
		.out_stall (out_stall)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic report_failure(input string why);
		if (why.len() > 0) begin
			$display("%s", why);
		end
		$display("Simulation FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_flag(input logic exp, input logic got, input string name);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, got);
			report_failure("");
		end
	endtask

	task automatic check_kind(input ray_if_pkg::ray_kind_e exp, input ray_if_pkg::ray_kind_e got,
			input string name);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			report_failure("");
		end
	endtask

	task automatic check_ray(input ray_if_pkg::ray_out_t exp, input ray_if_pkg::ray_out_t got,
			input string name);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			report_failure("");
		end
	endtask

	// each data line gives one hit record and its reflected direction.
	task automatic load_tests();
		int                   fd;
		int                   code;
		string                line;
		logic [7:0]           id;
		logic [47:0]          nrm;
		logic [47:0]          dr;
		logic [47:0]          pnt;
		logic [47:0]          refl;
		ray_if_pkg::hit_rec_t rec;
		ray_if_pkg::ray_out_t ray;
		fd = $fopen("bench/reflect_tests.dat", "r");
		if (fd == 0) begin
			report_failure("could not open bench/reflect_tests.dat");
		end
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
				code = $sscanf(line, "%h %h %h %h %h", id, nrm, dr, pnt, refl);
				if (code != 5) begin
					report_failure($sformatf("malformed line in test file: %s", line));
				end
				rec.ray_id = id;
				rec.normal = nrm;
				rec.dir = dr;
				rec.p_int = pnt;
				ray.ray_id = id;
				ray.kind = ray_if_pkg::kind_reflect;
				ray.origin = pnt;
				ray.dir = refl;
				hits.push_back(rec);
				rays.push_back(ray);
			end
		end
		$fclose(fd);
		if (hits.size() == 0) begin
			report_failure("the test file holds no records");
		end
	endtask

	// holds the record until the unit takes it, and ends a held output stall.
	task automatic send_record(input ray_if_pkg::hit_rec_t rec, input ray_if_pkg::ray_out_t exp);
		int waited;
		waited = 0;
		in_valid = 1'b1;
		in_hit = rec;
		@(negedge clk);
		while (in_stall) begin
			if (hold_stall && waited >= HOLD_CYCLES) begin
				saw_in_stall = 1'b1;
				hold_stall = 1'b0;
			end
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_failure("timeout while waiting for in_stall to fall");
			end
			@(negedge clk);
		end
		exp_q.push_back(exp);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic drain_outputs();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_failure("timeout while waiting for the outstanding rays to come out");
			end
			@(negedge clk);
		end
	endtask

	// roughly one cycle in three stalled, or solid while hold_stall is set.
	always @(posedge clk) begin
		stall_rng = xorshift32(stall_rng);
		stall_next = hold_stall || ((stall_rng % 3) == 0);
		#1;
		out_stall = stall_next;
	end

	always @(negedge clk) begin
		if (rst_n) begin
			if (held_valid) begin
				check_flag(1'b1, out_valid, "out_valid while stalled");
				check_ray(held_ray, out_ray, "out_ray while stalled");
			end
			if (out_valid && !out_stall) begin
				if (exp_q.size() == 0) begin
					report_failure("an output ray came out with no record outstanding");
				end
				expected = exp_q.pop_front();
				check_kind(ray_if_pkg::kind_reflect, out_ray.kind, "out_ray.kind");
				check_ray(expected, out_ray, "out_ray");
			end
			held_valid = out_valid && out_stall;
			held_ray = out_ray;
		end
	end

	initial begin
		int gap;
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_hit = '0;
		out_stall = 1'b0;
		hold_stall = 1'b0;
		saw_in_stall = 1'b0;
		held_valid = 1'b0;
		gap_rng = SEED;
		stall_rng = SEED;
		load_tests();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_flag(1'b0, out_valid, "out_valid");
		check_flag(1'b0, in_stall, "in_stall");
		@(posedge clk);
		#1;
		for (int i = 0; i < hits.size(); i++) begin
			// from here records go back to back against a blocked output.
			if (i == HOLD_FIRST) begin
				hold_stall = 1'b1;
			end
			gap_rng = xorshift32(gap_rng);
			gap = hold_stall ? 0 : int'(gap_rng[1:0]);
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			send_record(hits[i], rays[i]);
		end
		if (!saw_in_stall) begin
			report_failure("in_stall never rose while out_stall was held high");
		end
		drain_outputs();
		repeat (20) @(negedge clk);
		if (exp_q.size() == 0 && !out_valid) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			report_failure("an extra output ray is still pending at the end of the run");
		end
	end

endmodule : tb_reflect_unit

//--- design/reflect_unit.sv
`timescale 1ns/1ps

module reflect_unit #(
	parameter int NUM_LANES = 2,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  ray_if_pkg::hit_rec_t in_hit,
	output logic                 in_stall,
	output logic                 out_valid,
	output ray_if_pkg::ray_out_t out_ray,
	input  logic                 out_stall
);

	logic [NUM_LANES-1:0] lane_valid;
	ray_if_pkg::hit_rec_t lane_hit;
	logic [NUM_LANES-1:0] lane_stall;
	logic [NUM_LANES-1:0] lane_out_valid;
	ray_if_pkg::ray_out_t lane_out_ray [NUM_LANES];
	logic [NUM_LANES-1:0] lane_out_read;

	ray_dispatch #(
		.NUM_LANES (NUM_LANES)
	) dispatch_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_hit     (in_hit),
		.in_stall   (in_stall),
		.lane_valid (lane_valid),
		.lane_hit   (lane_hit),
		.lane_stall (lane_stall)
	);

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		reflect_lane #(
			.FIFO_DEPTH (FIFO_DEPTH)
		) lane_inst (
			.clk       (clk),
			.rst_n     (rst_n),
			.hit_valid (lane_valid[i]),
			.hit       (lane_hit),
			.hit_stall (lane_stall[i]),
			.out_valid (lane_out_valid[i]),
			.out_ray   (lane_out_ray[i]),
			.out_read  (lane_out_read[i])
		);
	end

	ray_collect #(
		.NUM_LANES (NUM_LANES)
	) collect_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.lane_out_valid (lane_out_valid),
		.lane_out_ray   (lane_out_ray),
		.lane_out_read  (lane_out_read),
		.out_valid      (out_valid),
		.out_ray        (out_ray),
		.out_stall      (out_stall)
	);

endmodule : reflect_unit

//--- design/ray_collect.sv
`timescale 1ns/1ps

module ray_collect #(
	parameter int NUM_LANES = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [NUM_LANES-1:0] lane_out_valid,
	input  ray_if_pkg::ray_out_t lane_out_ray [NUM_LANES],
	output logic [NUM_LANES-1:0] lane_out_read,
	output logic                 out_valid,
	output ray_if_pkg::ray_out_t out_ray,
	input  logic                 out_stall
);

	localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [PTR_W-1:0] rd_ptr;
	logic             take;

	// waits on the pointed lane even if others hold data, which keeps the order.
	assign out_valid = lane_out_valid[rd_ptr];
	assign out_ray = lane_out_ray[rd_ptr];
	assign take = out_valid && !out_stall;

	always_comb begin
		lane_out_read = '0;
		lane_out_read[rd_ptr] = take;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (take) begin
			if (rd_ptr == PTR_W'(NUM_LANES - 1)) begin
				rd_ptr <= '0;
			end else begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// a stalled output ray stays put until it is taken.
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && out_stall |=> out_valid && $stable(out_ray));

endmodule : ray_collect

//--- design/ray_dispatch.sv
`timescale 1ns/1ps

module ray_dispatch #(
	parameter int NUM_LANES = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  ray_if_pkg::hit_rec_t in_hit,
	output logic                 in_stall,
	output logic [NUM_LANES-1:0] lane_valid,
	output ray_if_pkg::hit_rec_t lane_hit,
	input  logic [NUM_LANES-1:0] lane_stall
);

	localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [PTR_W-1:0] wr_ptr;
	logic             accept;

	// only the lane under the pointer sees the record.
	assign in_stall = lane_stall[wr_ptr];
	assign accept = in_valid && !in_stall;
	assign lane_hit = in_hit;

	always_comb begin
		lane_valid = '0;
		lane_valid[wr_ptr] = in_valid;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (accept) begin
			if (wr_ptr == PTR_W'(NUM_LANES - 1)) begin
				wr_ptr <= '0;
			end else begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// a valid record must land in one real lane, so the pointer never runs past the last one.
	a_one_lane: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(lane_valid) && (!in_valid || $onehot(lane_valid)));

endmodule : ray_dispatch

//--- reflect_lane/reflect_lane.sv
`timescale 1ns/1ps

module reflect_lane #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 hit_valid,
	input  ray_if_pkg::hit_rec_t hit,
	output logic                 hit_stall,
	output logic                 out_valid,
	output ray_if_pkg::ray_out_t out_ray,
	input  logic                 out_read
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int SB_DEPTH = 4;

	logic                  accept;
	logic                  refl_valid;
	vec_math_pkg::vector_t refl_dir;
	ray_if_pkg::sideband_t sb_q [SB_DEPTH];
	ray_if_pkg::ray_out_t  fifo_in;
	logic                  fifo_empty;
	logic [CNT_W-1:0]      num_free;
	logic [CNT_W-1:0]      in_flight;

	// stall once every free slot is already claimed by a record in the pipe.
	assign hit_stall = in_flight >= num_free;
	assign accept = hit_valid && !hit_stall;

	reflector reflector_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.valid_in  (accept),
		.normal    (hit.normal),
		.dir       (hit.dir),
		.valid_out (refl_valid),
		.reflected (refl_dir)
	);

	// matches the reflector latency.
	always_ff @(posedge clk) begin
		sb_q[0] <= '{ray_id: hit.ray_id, p_int: hit.p_int};
		for (int i = 1; i < SB_DEPTH; i++) begin
			sb_q[i] <= sb_q[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_flight <= '0;
		end else if (accept && !refl_valid) begin
			in_flight <= in_flight + 1'b1;
		end else if (!accept && refl_valid) begin
			in_flight <= in_flight - 1'b1;
		end
	end

	assign fifo_in.ray_id = sb_q[SB_DEPTH-1].ray_id;
	assign fifo_in.kind = ray_if_pkg::kind_reflect;
	assign fifo_in.origin = sb_q[SB_DEPTH-1].p_int;
	assign fifo_in.dir = refl_dir;

	ray_fifo #(
		.WIDTH ($bits(ray_if_pkg::ray_out_t)),
		.DEPTH (FIFO_DEPTH)
	) fifo_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.data_in  (fifo_in),
		.we       (refl_valid),
		.re       (out_read),
		.data_out (out_ray),
		.full     (),
		.empty    (fifo_empty),
		.num_free (num_free)
	);

	assign out_valid = !fifo_empty;

	// records inside the reflector always have a reserved FIFO slot.
	a_credit: assert property (@(posedge clk) disable iff (!rst_n)
		in_flight <= num_free);

endmodule : reflect_lane

//--- reflect_lane/reflector.sv
`timescale 1ns/1ps

module reflector (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  valid_in,
	input  vec_math_pkg::vector_t normal,
	input  vec_math_pkg::vector_t dir,
	output logic                  valid_out,
	output vec_math_pkg::vector_t reflected
);

	localparam int COORD_W = vec_math_pkg::COORD_W;
	localparam int FRAC_W = vec_math_pkg::FRAC_W;
	localparam int PROD_W = 2 * COORD_W;
	localparam int SUM_W = PROD_W + 2;
	localparam int DOT_W = SUM_W - FRAC_W;
	localparam int SCALE_W = DOT_W + COORD_W;

	typedef struct packed {
		logic signed [PROD_W-1:0] x;
		logic signed [PROD_W-1:0] y;
		logic signed [PROD_W-1:0] z;
	} prod_vec_t;

	typedef struct packed {
		logic signed [SCALE_W-1:0] x;
		logic signed [SCALE_W-1:0] y;
		logic signed [SCALE_W-1:0] z;
	} scale_vec_t;

	logic [3:0]               valid_q;
	vec_math_pkg::vector_t    s1_normal;
	vec_math_pkg::vector_t    s1_dir;
	prod_vec_t                s1_prod;
	vec_math_pkg::vector_t    s2_normal;
	vec_math_pkg::vector_t    s2_dir;
	logic signed [DOT_W-1:0]  s2_dot;
	vec_math_pkg::vector_t    s3_dir;
	scale_vec_t               s3_scaled;
	logic signed [SUM_W-1:0]  dot_sum;

	// dir minus twice the shifted product, wrapping to COORD_W bits.
	function automatic vec_math_pkg::coord_t mirror(
		input vec_math_pkg::coord_t      d_in,
		input logic signed [SCALE_W-1:0] scaled
	);
		logic [COORD_W-1:0] twice;
		twice = {scaled[FRAC_W +: COORD_W-1], 1'b0};
		return d_in - twice;
	endfunction

	assign dot_sum = SUM_W'(s1_prod.x) + SUM_W'(s1_prod.y) + SUM_W'(s1_prod.z);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[2:0], valid_in};
		end
	end

	always_ff @(posedge clk) begin
		s1_normal <= normal;
		s1_dir <= dir;
		s1_prod.x <= PROD_W'(normal.x) * PROD_W'(dir.x);
		s1_prod.y <= PROD_W'(normal.y) * PROD_W'(dir.y);
		s1_prod.z <= PROD_W'(normal.z) * PROD_W'(dir.z);

		// upper slice of the sum is the floor shift.
		s2_normal <= s1_normal;
		s2_dir <= s1_dir;
		s2_dot <= dot_sum[SUM_W-1:FRAC_W];

		s3_dir <= s2_dir;
		s3_scaled.x <= SCALE_W'(s2_dot) * SCALE_W'(s2_normal.x);
		s3_scaled.y <= SCALE_W'(s2_dot) * SCALE_W'(s2_normal.y);
		s3_scaled.z <= SCALE_W'(s2_dot) * SCALE_W'(s2_normal.z);

		reflected.x <= mirror(s3_dir.x, s3_scaled.x);
		reflected.y <= mirror(s3_dir.y, s3_scaled.y);
		reflected.z <= mirror(s3_dir.z, s3_scaled.z);
	end

	assign valid_out = valid_q[3];

endmodule : reflector

//--- design/ray_fifo.sv
`timescale 1ns/1ps

module ray_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [WIDTH-1:0]             data_in,
	input  logic                         we,
	input  logic                         re,
	output logic [WIDTH-1:0]             data_out,
	output logic                         full,
	output logic                         empty,
	output logic [$clog2(DEPTH+1)-1:0]   num_free
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_write;
	logic             do_read;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign do_write = we && !full;
	assign do_read = re && !empty;
	assign full = count == CNT_W'(DEPTH);
	assign empty = count == '0;
	assign num_free = CNT_W'(DEPTH) - count;

	// show-ahead head entry.
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_read) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) we |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) re |-> !empty);

endmodule : ray_fifo

//--- common/ray_if_pkg.sv
package ray_if_pkg;

	localparam int RAY_ID_W = 8;

	typedef logic [RAY_ID_W-1:0] ray_id_t;

	typedef enum logic [1:0] {
		kind_primary = 2'd0,
		kind_reflect = 2'd1,
		kind_shadow  = 2'd2
	} ray_kind_e;

	// incoming hit record, 152 bits.
	typedef struct packed {
		ray_id_t               ray_id;
		vec_math_pkg::vector_t normal;
		vec_math_pkg::vector_t dir;
		vec_math_pkg::vector_t p_int;
	} hit_rec_t;

	// fields that ride beside the reflector pipeline.
	typedef struct packed {
		ray_id_t               ray_id;
		vec_math_pkg::vector_t p_int;
	} sideband_t;

	// outgoing ray, 106 bits.
	typedef struct packed {
		ray_id_t               ray_id;
		ray_kind_e             kind;
		vec_math_pkg::vector_t origin;
		vec_math_pkg::vector_t dir;
	} ray_out_t;

endpackage : ray_if_pkg

//--- common/vec_math_pkg.sv
package vec_math_pkg;

	// signed fixed point, 2 integer bits and 14 fraction bits.
	localparam int COORD_W = 16;
	localparam int FRAC_W = 14;

	typedef logic signed [COORD_W-1:0] coord_t;

	// 48 bits in all, x in the top slice.
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} vector_t;

endpackage : vec_math_pkg
